// ==== verilog/i2c_pkg.sv ====
package i2c_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int DATA_BITS      = 8;
    localparam int REG_ADDR_BITS  = 8;
    localparam int DEV_ADDR_BITS  = 7;
    localparam int DIVIDER_BITS   = 16;
    // room to count up to and including DATA_BITS
    localparam int BIT_COUNT_BITS = $clog2(DATA_BITS) + 1;

    ////////////////////////////////////////
    // request and state types
    ////////////////////////////////////////

    typedef struct packed {
        logic                     read;
        logic [DEV_ADDR_BITS-1:0] dev_addr;
        logic [REG_ADDR_BITS-1:0] reg_addr;
        logic [DATA_BITS-1:0]     write_data;
    } i2c_request_t;

    // quarter phases of one SCL bit period
    typedef enum logic [1:0] {
        PH_SETUP = 2'd0,
        PH_RISE  = 2'd1,
        PH_HIGH  = 2'd2,
        PH_FALL  = 2'd3
    } scl_phase_t;

    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_START      = 4'd1,
        ST_DEV_ADDR_W = 4'd2,
        ST_REG_ADDR   = 4'd3,
        ST_WRITE_DATA = 4'd4,
        ST_RESTART    = 4'd5,
        ST_DEV_ADDR_R = 4'd6,
        ST_READ_DATA  = 4'd7,
        ST_CHECK_ACK  = 4'd8,
        ST_SEND_NACK  = 4'd9,
        ST_STOP       = 4'd10
    } seq_state_t;

endpackage

// ==== verilog/scl_phase_timer.sv ====
`timescale 1ns/1ps

module scl_phase_timer import i2c_pkg::*; (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    run,
    input  logic [DIVIDER_BITS-1:0] divider,
    input  logic                    scl_in,
    output logic                    phase_tick,
    output scl_phase_t              phase
);

    logic [DIVIDER_BITS-1:0] count;
    scl_phase_t              next_phase;

    // one tick every divider+1 clocks
    // a divider of at least 1 keeps SDA edges clear of SCL edges
    assign phase_tick = run && (count == divider);

    always_comb begin
        case (phase)
            PH_SETUP: begin
                next_phase = PH_RISE;
            end
            PH_RISE: begin
                next_phase = PH_HIGH;
            end
            PH_HIGH: begin
                // target stretching, wait for SCL to actually go high
                next_phase = scl_in ? PH_FALL : PH_HIGH;
            end
            default: begin
                next_phase = PH_SETUP;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n || !run) begin
            count <= '0;
            phase <= PH_SETUP;
        end else if (phase_tick) begin
            count <= '0;
            phase <= next_phase;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== verilog/i2c_byte_shifter.sv ====
`timescale 1ns/1ps

module i2c_byte_shifter import i2c_pkg::*; (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 load,
    input  logic [DATA_BITS-1:0] load_byte,
    input  logic                 shift,
    input  logic                 sample,
    input  logic                 sda_in,
    output logic                 tx_bit,
    output logic                 byte_done,
    output logic [DATA_BITS-1:0] rx_byte
);

    logic [DATA_BITS-1:0]      shift_reg;
    logic [BIT_COUNT_BITS-1:0] bit_count;

    ////////////////////////////////////////
    // data path
    ////////////////////////////////////////

    // msb first in both directions
    always_ff @(posedge clock) begin
        if (load) begin
            shift_reg <= load_byte;
        end else if (sample) begin
            shift_reg <= {shift_reg[DATA_BITS-2:0], sda_in};
        end else if (shift) begin
            // fill with ones so SDA idles released
            shift_reg <= {shift_reg[DATA_BITS-2:0], 1'b1};
        end
    end

    assign tx_bit  = shift_reg[DATA_BITS-1];
    assign rx_byte = shift_reg;

    ////////////////////////////////////////
    // bit counter
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            bit_count <= '0;
        end else if (load) begin
            bit_count <= '0;
        end else if (shift || sample) begin
            bit_count <= bit_count + 1'b1;
        end
    end

    assign byte_done = (bit_count == BIT_COUNT_BITS'(DATA_BITS));

endmodule

// ==== verilog/i2c_sequencer.sv ====
`timescale 1ns/1ps

module i2c_sequencer import i2c_pkg::*; (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 start,
    input  i2c_request_t         held_request,
    input  logic                 phase_tick,
    input  scl_phase_t           phase,
    input  logic                 tx_bit,
    input  logic                 byte_done,
    input  logic [DATA_BITS-1:0] rx_byte,
    input  logic                 sda_in,
    output logic                 run,
    output logic                 load,
    output logic [DATA_BITS-1:0] load_byte,
    output logic                 shift,
    output logic                 sample,
    output logic                 scl_oe,
    output logic                 sda_oe,
    output logic                 busy,
    output logic                 nack,
    output logic [DATA_BITS-1:0] read_data
);

    seq_state_t state;
    seq_state_t next_state;
    seq_state_t ack_return;
    seq_state_t follow_state;
    logic       was_high;
    logic       fall_entry;
    logic       bit_end;
    logic       sending;
    logic       sda_next;

    assign run  = (state != ST_IDLE);
    assign busy = run;

    // SCL released only for the high and fall quarters
    assign scl_oe = run && (phase == PH_SETUP || phase == PH_RISE);

    assign bit_end = phase_tick && (phase == PH_FALL);
    // first clock after the high quarter, SCL is known to be high here
    assign fall_entry = was_high && (phase == PH_FALL);

    assign sending = state inside {ST_DEV_ADDR_W, ST_REG_ADDR, ST_WRITE_DATA, ST_DEV_ADDR_R};
    assign shift   = fall_entry && sending;
    assign sample  = fall_entry && (state == ST_READ_DATA);

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    next_state = ST_START;
                end
            end
            ST_START: begin
                if (bit_end) begin
                    next_state = ST_DEV_ADDR_W;
                end
            end
            ST_RESTART: begin
                if (bit_end) begin
                    next_state = ST_DEV_ADDR_R;
                end
            end
            ST_DEV_ADDR_W, ST_REG_ADDR, ST_WRITE_DATA, ST_DEV_ADDR_R: begin
                if (bit_end && byte_done) begin
                    next_state = ST_CHECK_ACK;
                end
            end
            ST_CHECK_ACK: begin
                if (bit_end) begin
                    next_state = nack ? ST_STOP : ack_return;
                end
            end
            ST_READ_DATA: begin
                if (bit_end && byte_done) begin
                    next_state = ST_SEND_NACK;
                end
            end
            ST_SEND_NACK: begin
                if (bit_end) begin
                    next_state = ST_STOP;
                end
            end
            ST_STOP: begin
                if (bit_end) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // where to go once the acknowledge is good
    always_comb begin
        case (state)
            ST_DEV_ADDR_W: follow_state = ST_REG_ADDR;
            ST_REG_ADDR:   follow_state = held_request.read ? ST_RESTART : ST_WRITE_DATA;
            ST_DEV_ADDR_R: follow_state = ST_READ_DATA;
            default:       follow_state = ST_STOP;
        endcase
    end

    // shifter is loaded on entry to each byte state
    always_comb begin
        case (next_state)
            ST_DEV_ADDR_W: load_byte = {held_request.dev_addr, 1'b0};
            ST_DEV_ADDR_R: load_byte = {held_request.dev_addr, 1'b1};
            ST_REG_ADDR:   load_byte = held_request.reg_addr;
            ST_WRITE_DATA: load_byte = held_request.write_data;
            default:       load_byte = '0;
        endcase
    end

    assign load = (next_state != state) && (next_state inside
        {ST_DEV_ADDR_W, ST_REG_ADDR, ST_WRITE_DATA, ST_DEV_ADDR_R, ST_READ_DATA});

    ////////////////////////////////////////
    // SDA drive
    ////////////////////////////////////////

    // registered, so SDA moves one clock after the phase boundary
    always_comb begin
        case (state)
            ST_START, ST_RESTART: begin
                // falls while SCL is high
                sda_next = (phase == PH_FALL);
            end
            ST_STOP: begin
                // rises while SCL is high
                sda_next = (phase != PH_FALL);
            end
            ST_DEV_ADDR_W, ST_REG_ADDR, ST_WRITE_DATA, ST_DEV_ADDR_R: begin
                sda_next = (phase == PH_SETUP) ? !tx_bit : sda_oe;
            end
            default: begin
                // ack, read data and nack leave SDA released
                sda_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= ST_IDLE;
            ack_return <= ST_STOP;
            was_high   <= 1'b0;
            sda_oe     <= 1'b0;
            nack       <= 1'b0;
            read_data  <= '0;
        end else begin
            state    <= next_state;
            was_high <= (phase == PH_HIGH);
            sda_oe   <= sda_next;
            if (sending) begin
                ack_return <= follow_state;
            end
            if (state == ST_IDLE && start) begin
                nack <= 1'b0;
            end else if (state == ST_CHECK_ACK && fall_entry && sda_in) begin
                nack <= 1'b1;
            end
            if (state == ST_READ_DATA && bit_end && byte_done) begin
                read_data <= rx_byte;
            end
        end
    end

endmodule

// ==== verilog/i2c_master_top.sv ====
`timescale 1ns/1ps

module i2c_master_top import i2c_pkg::*; (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    enable,
    input  i2c_request_t            request,
    input  logic [DIVIDER_BITS-1:0] divider,
    input  logic                    scl_in,
    input  logic                    sda_in,
    output logic                    busy,
    output logic [DATA_BITS-1:0]    read_data,
    output logic                    nack,
    output logic                    scl_oe,
    output logic                    sda_oe
);

    logic                 start;
    i2c_request_t         held_request;
    logic                 phase_tick;
    scl_phase_t           phase;
    logic                 run;
    logic                 load;
    logic [DATA_BITS-1:0] load_byte;
    logic                 shift;
    logic                 sample;
    logic                 tx_bit;
    logic                 byte_done;
    logic [DATA_BITS-1:0] rx_byte;

    // enable is ignored while a transfer is in flight
    assign start = enable && !busy;

    always_ff @(posedge clock) begin
        if (start) begin
            held_request <= request;
        end
    end

    ////////////////////////////////////////
    // timer, shifter, sequencer
    ////////////////////////////////////////

    scl_phase_timer phase_timer0 (
        .clock      (clock),
        .reset_n    (reset_n),
        .run        (run),
        .divider    (divider),
        .scl_in     (scl_in),
        .phase_tick (phase_tick),
        .phase      (phase)
    );

    i2c_byte_shifter shifter0 (
        .clock     (clock),
        .reset_n   (reset_n),
        .load      (load),
        .load_byte (load_byte),
        .shift     (shift),
        .sample    (sample),
        .sda_in    (sda_in),
        .tx_bit    (tx_bit),
        .byte_done (byte_done),
        .rx_byte   (rx_byte)
    );

    i2c_sequencer sequencer0 (
        .clock        (clock),
        .reset_n      (reset_n),
        .start        (start),
        .held_request (held_request),
        .phase_tick   (phase_tick),
        .phase        (phase),
        .tx_bit       (tx_bit),
        .byte_done    (byte_done),
        .rx_byte      (rx_byte),
        .sda_in       (sda_in),
        .run          (run),
        .load         (load),
        .load_byte    (load_byte),
        .shift        (shift),
        .sample       (sample),
        .scl_oe       (scl_oe),
        .sda_oe       (sda_oe),
        .busy         (busy),
        .nack         (nack),
        .read_data    (read_data)
    );

endmodule

// ==== sim/i2c_slave_model.sv ====
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input  logic clock,
    input  logic reset_n,
    input  logic stretch_enable,
    input  logic scl,
    input  logic sda,
    output logic scl_oe,
    output logic sda_oe
);

    typedef enum logic [2:0] {M_IDLE, M_ADDR, M_REG, M_WRITE, M_READ} mode_t;

    mode_t      mode;
    logic [7:0] regs [0:255];
    logic [7:0] reg_ptr;
    logic [7:0] shreg;
    logic [7:0] read_byte;
    logic [3:0] bit_cnt;
    logic [4:0] stretch_count;
    logic       scl_q;
    logic       sda_q;
    logic       start_det;
    logic       stop_det;
    logic       scl_rise;
    logic       scl_fall;

    assign start_det = scl && scl_q && sda_q && !sda;
    assign stop_det  = scl && scl_q && !sda_q && sda;
    assign scl_rise  = scl && !scl_q;
    assign scl_fall  = !scl && scl_q;
    assign scl_oe    = (stretch_count != 5'd0);

    ////////////////////////////////////////
    // bus tracking
    ////////////////////////////////////////

    always @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < 256; i++) begin
                regs[i] <= 8'(i) ^ 8'hA5;
            end
            mode          <= M_IDLE;
            reg_ptr       <= 8'h00;
            shreg         <= 8'h00;
            read_byte     <= 8'h00;
            bit_cnt       <= 4'd0;
            stretch_count <= 5'd0;
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
            sda_oe        <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (stretch_count != 5'd0) begin
                stretch_count <= stretch_count - 5'd1;
            end
            if (start_det) begin
                mode    <= M_ADDR;
                bit_cnt <= 4'd0;
                sda_oe  <= 1'b0;
            end else if (stop_det) begin
                mode   <= M_IDLE;
                sda_oe <= 1'b0;
            end else if (scl_rise && mode != M_IDLE) begin
                if (mode == M_READ) begin
                    // master nack after the eighth bit ends the read
                    if (bit_cnt < 4'd8) begin
                        read_byte <= {read_byte[6:0], 1'b1};
                        bit_cnt   <= bit_cnt + 4'd1;
                    end else if (bit_cnt == 4'd8) begin
                        mode <= M_IDLE;
                    end
                end else if (bit_cnt < 4'd8) begin
                    shreg   <= {shreg[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (scl_fall && mode != M_IDLE) begin
                if (stretch_enable) begin
                    stretch_count <= 5'($urandom_range(20, 0));
                end
                if (bit_cnt == 4'd9) begin
                    // end of our ack bit
                    bit_cnt <= 4'd0;
                    sda_oe  <= (mode == M_READ) ? !read_byte[7] : 1'b0;
                end else if (mode == M_READ) begin
                    sda_oe <= (bit_cnt < 4'd8) ? !read_byte[7] : 1'b0;
                end else if (bit_cnt == 4'd8) begin
                    bit_cnt <= 4'd9;
                    case (mode)
                        M_ADDR: begin
                            if (shreg[7:1] == DEV_ADDR) begin
                                sda_oe    <= 1'b1;
                                mode      <= shreg[0] ? M_READ : M_REG;
                                read_byte <= regs[reg_ptr];
                            end else begin
                                mode <= M_IDLE;
                            end
                        end
                        M_REG: begin
                            reg_ptr <= shreg;
                            sda_oe  <= 1'b1;
                            mode    <= M_WRITE;
                        end
                        default: begin
                            regs[reg_ptr] <= shreg;
                            reg_ptr       <= reg_ptr + 8'd1;
                            sda_oe        <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

endmodule

// ==== sim/i2c_master_props.sv ====
`timescale 1ns/1ps

module i2c_master_props import i2c_pkg::*; (
    input logic       clock,
    input logic       reset_n,
    input logic       scl_in,
    input logic       sda_in,
    input logic       busy,
    input logic       scl_oe,
    input logic       sda_oe,
    input seq_state_t state
);

    ////////////////////////////////////////
    // bus conditions
    ////////////////////////////////////////

    // SDA moved while SCL stayed released
    sda_stable_when_scl_high: assert property (
        @(posedge clock) disable iff (!reset_n)
        (scl_in && $past(scl_in) && (sda_in != $past(sda_in)))
            |-> ((state inside {ST_START, ST_RESTART, ST_STOP})
                || ($past(state) inside {ST_START, ST_RESTART, ST_STOP}))
    ) else $error("SDA changed while SCL high outside a START, repeated START or STOP");

    ////////////////////////////////////////
    // busy behaviour
    ////////////////////////////////////////

    idle_lines_released: assert property (
        @(posedge clock) disable iff (!reset_n)
        !busy |-> (!scl_oe && !sda_oe)
    ) else $error("a bus line is pulled low while the master is idle");

    idle_after_reset: assert property (
        @(posedge clock)
        $rose(reset_n) |-> !busy
    ) else $error("busy is high in the cycle after reset");

endmodule

// ==== sim/tb_i2c_master.sv ====
`timescale 1ns/1ps

module tb_i2c_master import i2c_pkg::*;;

    localparam int  TRANSFERS  = 40;
    localparam int  BITS       = 30;
    localparam real WATCHDOG_NS = TRANSFERS * BITS * 4 * 24 * 40.0;

    logic                    clock;
    logic                    reset_n;
    logic                    enable;
    i2c_request_t            request;
    logic [DIVIDER_BITS-1:0] divider;
    logic                    busy;
    logic [DATA_BITS-1:0]    read_data;
    logic                    nack;
    logic                    scl_oe;
    logic                    sda_oe;
    logic                    slave_scl_oe;
    logic                    slave_sda_oe;
    logic                    stretch_enable;
    logic                    scl;
    logic                    sda;
    logic [7:0]              exp_regs [0:255];
    logic                    written [0:255];
    int                      errors;

    // open-drain wired-AND
    assign scl = !(scl_oe || slave_scl_oe);
    assign sda = !(sda_oe || slave_sda_oe);

    always #20 clock = !clock;

    i2c_master_top dut0 (
        .clock     (clock),
        .reset_n   (reset_n),
        .enable    (enable),
        .request   (request),
        .divider   (divider),
        .scl_in    (scl),
        .sda_in    (sda),
        .busy      (busy),
        .read_data (read_data),
        .nack      (nack),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe)
    );

    i2c_slave_model #(.DEV_ADDR(7'h50)) slave0 (
        .clock          (clock),
        .reset_n        (reset_n),
        .stretch_enable (stretch_enable),
        .scl            (scl),
        .sda            (sda),
        .scl_oe         (slave_scl_oe),
        .sda_oe         (slave_sda_oe)
    );

    bind i2c_master_top i2c_master_props props0 (
        .clock   (clock),
        .reset_n (reset_n),
        .scl_in  (scl_in),
        .sda_in  (sda_in),
        .busy    (busy),
        .scl_oe  (scl_oe),
        .sda_oe  (sda_oe),
        .state   (sequencer0.state)
    );

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // issue one request and wait for it to finish
    task automatic run_transfer(input logic rd, input logic [6:0] dev,
                                input logic [7:0] ra, input logic [7:0] wd);
        @(posedge clock);
        #1;
        request = '{read: rd, dev_addr: dev, reg_addr: ra, write_data: wd};
        enable  = 1'b1;
        @(posedge clock);
        #1;
        enable = 1'b0;
        while (busy) begin
            @(negedge clock);
        end
        if (!rd && dev == 7'h50) begin
            exp_regs[ra] = wd;
            written[ra]  = 1'b1;
        end
    endtask

    task automatic write_read_pairs(input int count, input string name);
        logic [7:0] ra;
        logic [7:0] wd;
        for (int i = 0; i < count; i++) begin
            ra = 8'($urandom_range(255, 0));
            wd = 8'($urandom_range(255, 0));
            run_transfer(1'b0, 7'h50, ra, wd);
            check_value({name, " write nack"}, 8'h00, {7'h00, nack});
            run_transfer(1'b1, 7'h50, ra, 8'h00);
            check_value({name, " read data"}, exp_regs[ra], read_data);
            check_value({name, " read nack"}, 8'h00, {7'h00, nack});
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [7:0] ra;
        logic [7:0] other;
        void'($urandom(32'haa10_5d8a));
        clock          = 1'b0;
        reset_n        = 1'b0;
        enable         = 1'b0;
        request        = '0;
        divider        = 16'd3;
        stretch_enable = 1'b0;
        errors         = 0;
        for (int i = 0; i < 256; i++) begin
            exp_regs[i] = 8'(i) ^ 8'hA5;
            written[i]  = 1'b0;
        end
        repeat (16) @(posedge clock);
        #1;
        reset_n = 1'b1;

        // idle after reset
        repeat (10) begin
            @(negedge clock);
            check_value("reset busy", 8'h00, {7'h00, busy});
            check_value("reset nack", 8'h00, {7'h00, nack});
            check_value("reset lines", 8'h03, {6'h00, scl, sda});
        end

        write_read_pairs(8, "write then read");

        // untouched register
        ra = 8'($urandom_range(255, 0));
        while (written[ra]) begin
            ra = ra + 8'd1;
        end
        run_transfer(1'b1, 7'h50, ra, 8'h00);
        check_value("unwritten read", 8'(ra) ^ 8'hA5, read_data);

        // nobody answers at 7'h51
        run_transfer(1'b0, 7'h51, ra, ~exp_regs[ra]);
        check_value("wrong address nack", 8'h01, {7'h00, nack});
        run_transfer(1'b1, 7'h50, ra, 8'h00);
        check_value("after nack read", exp_regs[ra], read_data);
        check_value("after nack nack", 8'h00, {7'h00, nack});

        stretch_enable = 1'b1;
        write_read_pairs(8, "stretched");
        stretch_enable = 1'b0;

        // second enable during a transfer must be dropped
        ra    = 8'($urandom_range(255, 0));
        other = ra + 8'd1;
        @(posedge clock);
        #1;
        request = '{read: 1'b1, dev_addr: 7'h50, reg_addr: ra, write_data: 8'h00};
        enable  = 1'b1;
        @(posedge clock);
        #1;
        enable = 1'b0;
        repeat (20) @(posedge clock);
        #1;
        request = '{read: 1'b0, dev_addr: 7'h50, reg_addr: other,
                    write_data: ~exp_regs[other]};
        enable  = 1'b1;
        @(posedge clock);
        #1;
        enable = 1'b0;
        while (busy) begin
            @(negedge clock);
        end
        check_value("busy enable read", exp_regs[ra], read_data);
        repeat (40) begin
            @(negedge clock);
            check_value("no second transfer", 8'h00, {7'h00, busy});
        end
        run_transfer(1'b1, 7'h50, other, 8'h00);
        check_value("dropped write", exp_regs[other], read_data);

        $display("tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/i2c_pkg.sv
verilog/scl_phase_timer.sv
verilog/i2c_byte_shifter.sv
verilog/i2c_sequencer.sv
verilog/i2c_master_top.sv
sim/i2c_slave_model.sv
sim/i2c_master_props.sv
sim/tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run; the result is decided by the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -f sources.f --top-module tb_i2c_master &&
./obj_dir/Vtb_i2c_master | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
